// ==== hw/ptw_pkg.sv ====
/*
 * Sv39 page table walker shared definitions
 * Holds the virtual and physical page number layouts, the page table entry,
 * the walk request and response, and the level, exception and controller
 * state encodings used by every block of the walker
 */

package ptw_pkg;

  // byte offset inside a 4 KiB page
  localparam int unsigned PAGE_OFFSET_W = 12;
  // an Sv39 entry is 8 bytes wide
  localparam int unsigned PTE_SIZE_LOG2 = 3;

  // virtual page number, one 9-bit index per table level
  typedef struct packed {
    logic [8:0] vp2;
    logic [8:0] vp1;
    logic [8:0] vp0;
  } vpn_t;

  // physical page number as it sits inside an entry
  typedef struct packed {
    logic [25:0] p2;
    logic [8:0]  p1;
    logic [8:0]  p0;
  } ppn_t;

  // entry control bits, v is the least significant bit
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_ctrl_t;

  // full 64-bit page table entry as read from memory
  typedef struct packed {
    logic [9:0]  reserved;
    ppn_t        ppn;
    logic [1:0]  rsw;
    pte_ctrl_t   ctrl;
  } pte_t;

  // Root marks the table root address, not an entry
  // a leaf at L3 maps a gibi-page, at L2 a mebi-page, at L1 a 4 KiB page
  typedef enum logic [1:0] {
    Root,
    L3,
    L2,
    L1
  } pte_level_e;

  typedef enum logic {
    NoException,
    PageFault
  } exception_e;

  // walk request from the TLB
  typedef struct packed {
    vpn_t vpn;
    ppn_t root;
  } ptw_req_t;

  // walk answer to the TLB, level gives the page size of the translation
  typedef struct packed {
    ppn_t       ppn;
    pte_level_e level;
    pte_ctrl_t  ctrl;
    exception_e exc;
  } ptw_resp_t;

  // walk controller states
  typedef enum logic [2:0] {
    Idle,
    Check,
    Fetch,
    Respond,
    WaitDrop
  } ptw_state_e;

endpackage

// ==== hw/pte_checker.sv ====
/*
 * Page table entry checker
 * Looks at one entry, or at the table root, and tells whether the walk ends
 * here with a translation, ends with a page fault, or goes one level down
 */

`timescale 1ns/1ps

module pte_checker (
  input  ptw_pkg::pte_level_e pte_level_i,
  input  ptw_pkg::ppn_t       ppn_i,
  input  ptw_pkg::pte_ctrl_t  pte_ctrl_i,
  input  logic                chk_en_i,
  output ptw_pkg::exception_e exception_o,
  output logic                done_o
);

  import ptw_pkg::*;

  // an entry with r or x set maps memory, otherwise it points to a table
  logic is_leaf;

  assign is_leaf = pte_ctrl_i.r | pte_ctrl_i.x;

  always_comb begin
    exception_o = NoException;
    done_o      = 1'b0;
    // the root address is never checked, the walk always fetches below it
    if (chk_en_i && (pte_level_i != Root)) begin
      done_o = 1'b1;
      // invalid entries and the reserved w-without-r encoding fault at once
      if (!pte_ctrl_i.v || (pte_ctrl_i.w && !pte_ctrl_i.r)) begin
        exception_o = PageFault;
      end else if (is_leaf) begin
        // the TLB does not set the access bit, so a cleared one faults
        if (!pte_ctrl_i.a) begin
          exception_o = PageFault;
        end else if ((pte_level_i == L3) && ({ppn_i.p1, ppn_i.p0} != '0)) begin
          // a gibi-page must be aligned to 1 GiB
          exception_o = PageFault;
        end else if ((pte_level_i == L2) && (ppn_i.p0 != '0)) begin
          // a mebi-page must be aligned to 2 MiB
          exception_o = PageFault;
        end
      end else if (pte_level_i == L1) begin
        // there is no table below the last level
        exception_o = PageFault;
      end else begin
        // a valid pointer at L3 or L2, keep walking
        done_o = 1'b0;
      end
    end
  end

  // the controller relies on a fault always ending the walk
  always_comb begin
    assert (!((exception_o == PageFault) && !done_o))
      else $error("pte_checker: page fault without done");
    assert (chk_en_i || !done_o)
      else $error("pte_checker: done raised with no check requested");
  end

endmodule

// ==== hw/ptw_mem_port.sv ====
/*
 * Page table walker memory port
 * Four-phase req/ack master that reads one 64-bit entry per fetch, holds it
 * for the controller and reports completion once the acknowledge has fallen
 */

`timescale 1ns/1ps

module ptw_mem_port #(
  parameter int unsigned PADDR_W = 56
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fetch_start_i,
  input  logic [PADDR_W-1:0] fetch_addr_i,
  output logic               fetch_done_o,
  output ptw_pkg::pte_t      fetch_pte_o,
  output logic               mem_req_o,
  output logic [PADDR_W-1:0] mem_addr_o,
  input  logic               mem_ack_i,
  input  logic [63:0]        mem_rdata_i
);

  import ptw_pkg::*;

  // PortIdle issues the request, PortWaitAck waits for the ack to rise,
  // PortWaitDrop has dropped the request and waits for the ack to fall
  typedef enum logic [1:0] {
    PortIdle,
    PortWaitAck,
    PortWaitDrop
  } port_state_e;

  port_state_e        state_q;
  logic               mem_req_q;
  logic [PADDR_W-1:0] addr_q;
  pte_t               pte_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= PortIdle;
      mem_req_q <= 1'b0;
    end else begin
      case (state_q)
        PortIdle: begin
          // the request goes out the cycle after the start pulse
          if (fetch_start_i) begin
            state_q   <= PortWaitAck;
            mem_req_q <= 1'b1;
          end
        end
        PortWaitAck: begin
          // a slow memory simply keeps us here
          if (mem_ack_i) begin
            state_q   <= PortWaitDrop;
            mem_req_q <= 1'b0;
          end
        end
        PortWaitDrop: begin
          if (!mem_ack_i) begin
            state_q <= PortIdle;
          end
        end
        default: state_q <= PortIdle;
      endcase
    end
  end

  // address and read data are captured on the handshake edges only
  always_ff @(posedge clk_i) begin
    if ((state_q == PortIdle) && fetch_start_i) begin
      addr_q <= fetch_addr_i;
    end
    if ((state_q == PortWaitAck) && mem_ack_i) begin
      pte_q <= pte_t'(mem_rdata_i);
    end
  end

  assign mem_req_o    = mem_req_q;
  assign mem_addr_o   = addr_q;
  assign fetch_pte_o  = pte_q;
  // the entry is already held, completion waits only for the ack to fall
  assign fetch_done_o = (state_q == PortWaitDrop) && !mem_ack_i;

  // the memory may sample the address on any cycle of the request
  a_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o |=> !mem_req_o || $stable(mem_addr_o))
    else $error("ptw_mem_port: address changed during a request");

  // the controller has at most one fetch outstanding
  a_no_start_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_start_i |-> (state_q == PortIdle))
    else $error("ptw_mem_port: fetch started while busy");

endmodule

// ==== hw/ptw_ctrl.sv ====
/*
 * Page table walk controller
 * Accepts a walk from the TLB, steps from the root down through the levels,
 * computes each entry address, and returns the translation or the fault
 * with a four-phase handshake
 */

`timescale 1ns/1ps

module ptw_ctrl #(
  parameter int unsigned PADDR_W = 56
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                walk_req_i,
  input  ptw_pkg::ptw_req_t   walk_data_i,
  output logic                walk_ack_o,
  output ptw_pkg::ptw_resp_t  walk_resp_o,
  output logic                fetch_start_o,
  output logic [PADDR_W-1:0]  fetch_addr_o,
  input  logic                fetch_done_i,
  input  ptw_pkg::pte_t       fetch_pte_i,
  output ptw_pkg::pte_level_e chk_level_o,
  output ptw_pkg::ppn_t       chk_ppn_o,
  output ptw_pkg::pte_ctrl_t  chk_ctrl_o,
  output logic                chk_en_o,
  input  ptw_pkg::exception_e chk_exc_i,
  input  logic                chk_done_i
);

  import ptw_pkg::*;

  // a ppn shifted by the page offset spans the full Sv39 physical space
  localparam int unsigned FULL_W = $bits(ppn_t) + PAGE_OFFSET_W;

  ptw_state_e        state_q;
  ptw_state_e        state_d;
  pte_level_e        level_q;
  pte_level_e        next_level;
  vpn_t              vpn_q;
  ppn_t              ppn_q;
  pte_ctrl_t         ctrl_q;
  ptw_resp_t         resp_q;
  logic [8:0]        vpn_idx;
  logic [FULL_W-1:0] pte_addr;

  // the level below the current one, L1 has nothing below it
  always_comb begin
    case (level_q)
      Root:    next_level = L3;
      L3:      next_level = L2;
      default: next_level = L1;
    endcase
  end

  // index into the next table comes from the vpn slice of the next level
  always_comb begin
    case (level_q)
      Root:    vpn_idx = vpn_q.vp2;
      L3:      vpn_idx = vpn_q.vp1;
      default: vpn_idx = vpn_q.vp0;
    endcase
  end

  // table base is ppn times the page size, each entry takes eight bytes
  assign pte_addr = (FULL_W'(ppn_q) << PAGE_OFFSET_W) | (FULL_W'(vpn_idx) << PTE_SIZE_LOG2);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (walk_req_i) begin
          state_d = Check;
        end
      end
      // one decision per level, the checker answers in the same cycle
      Check:    state_d = chk_done_i ? Respond : Fetch;
      Fetch: begin
        if (fetch_done_i) begin
          state_d = Check;
        end
      end
      Respond:  state_d = WaitDrop;
      WaitDrop: begin
        // hold the answer until the TLB lets go of the request
        if (!walk_req_i) begin
          state_d = Idle;
        end
      end
      default:  state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      level_q <= Root;
    end else begin
      state_q <= state_d;
      if ((state_q == Idle) && walk_req_i) begin
        level_q <= Root;
      end else if ((state_q == Fetch) && fetch_done_i) begin
        level_q <= next_level;
      end
    end
  end

  // walk context and the response are plain data registers
  always_ff @(posedge clk_i) begin
    if ((state_q == Idle) && walk_req_i) begin
      vpn_q  <= walk_data_i.vpn;
      ppn_q  <= walk_data_i.root;
      ctrl_q <= '0;
    end else if ((state_q == Fetch) && fetch_done_i) begin
      ppn_q  <= fetch_pte_i.ppn;
      ctrl_q <= fetch_pte_i.ctrl;
    end
    if ((state_q == Check) && chk_done_i) begin
      resp_q <= '{ppn: ppn_q, level: level_q, ctrl: ctrl_q, exc: chk_exc_i};
    end
  end

  assign chk_en_o      = (state_q == Check);
  assign chk_level_o   = level_q;
  assign chk_ppn_o     = ppn_q;
  assign chk_ctrl_o    = ctrl_q;
  // a single cycle pulse, Check is always left on the next edge
  assign fetch_start_o = (state_q == Check) && !chk_done_i;
  assign fetch_addr_o  = pte_addr[PADDR_W-1:0];
  assign walk_ack_o    = (state_q == Respond) || (state_q == WaitDrop);
  assign walk_resp_o   = resp_q;

  // the TLB may sample the response anywhere inside the ack window
  a_resp_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    walk_ack_o |=> !walk_ack_o || $stable(walk_resp_o))
    else $error("ptw_ctrl: response changed while acknowledged");

  // the checker must stop every walk at the last level
  a_no_fetch_below_l1 : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_start_o |-> (level_q != L1))
    else $error("ptw_ctrl: fetch requested below the last level");

  // the port only completes a fetch that this controller started
  a_done_in_fetch : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_done_i |-> (state_q == Fetch))
    else $error("ptw_ctrl: fetch completion outside the Fetch state");

endmodule

// ==== hw/ptw_top.sv ====
/*
 * Sv39 page table walker top level
 * Joins the walk controller, the entry checker and the memory port
 */

`timescale 1ns/1ps

module ptw_top #(
  parameter int unsigned PADDR_W = 56
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               walk_req_i,
  input  ptw_pkg::ptw_req_t  walk_data_i,
  output logic               walk_ack_o,
  output ptw_pkg::ptw_resp_t walk_resp_o,
  output logic               mem_req_o,
  output logic [PADDR_W-1:0] mem_addr_o,
  input  logic               mem_ack_i,
  input  logic [63:0]        mem_rdata_i
);

  import ptw_pkg::*;

  // controller to memory port
  logic               fetch_start;
  logic               fetch_done;
  logic [PADDR_W-1:0] fetch_addr;
  pte_t               fetch_pte;

  // controller to checker and back
  pte_level_e         chk_level;
  ppn_t               chk_ppn;
  pte_ctrl_t          chk_ctrl;
  logic               chk_en;
  logic               chk_done;
  exception_e         chk_exc;

  ptw_ctrl #(
    .PADDR_W (PADDR_W)
  ) ptw_ctrl_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .walk_req_i    (walk_req_i),
    .walk_data_i   (walk_data_i),
    .walk_ack_o    (walk_ack_o),
    .walk_resp_o   (walk_resp_o),
    .fetch_start_o (fetch_start),
    .fetch_addr_o  (fetch_addr),
    .fetch_done_i  (fetch_done),
    .fetch_pte_i   (fetch_pte),
    .chk_level_o   (chk_level),
    .chk_ppn_o     (chk_ppn),
    .chk_ctrl_o    (chk_ctrl),
    .chk_en_o      (chk_en),
    .chk_exc_i     (chk_exc),
    .chk_done_i    (chk_done)
  );

  pte_checker pte_checker_i (
    .pte_level_i (chk_level),
    .ppn_i       (chk_ppn),
    .pte_ctrl_i  (chk_ctrl),
    .chk_en_i    (chk_en),
    .exception_o (chk_exc),
    .done_o      (chk_done)
  );

  ptw_mem_port #(
    .PADDR_W (PADDR_W)
  ) ptw_mem_port_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_start_i (fetch_start),
    .fetch_addr_i  (fetch_addr),
    .fetch_done_o  (fetch_done),
    .fetch_pte_o   (fetch_pte),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i)
  );

endmodule

// ==== dv/tb_pt_mem.sv ====
/*
 * Page table memory model for the walker testbench
 * Sparse store of 64-bit entries behind a four-phase req/ack slave, with an
 * acknowledge delay of 0 to 3 cycles drawn from a linear congruential generator
 */

`timescale 1ns/1ps

module tb_pt_mem #(
  parameter int unsigned PADDR_W = 56
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               mem_req_i,
  input  logic [PADDR_W-1:0] mem_addr_i,
  output logic               mem_ack_o,
  output logic [63:0]        mem_rdata_o
);

  // only the entries that the tests place are stored
  logic [63:0] entries [logic [PADDR_W-1:0]];

  int unsigned rng_state = 92;
  logic        ack_q     = 1'b0;
  logic [63:0] rdata_q   = '0;
  logic        busy_q    = 1'b0;
  logic [1:0]  delay_q   = '0;

  task automatic write_entry(input logic [PADDR_W-1:0] addr, input logic [63:0] data);
    entries[addr] = data;
  endtask

  // unwritten words read back as the address with a cleared low byte,
  // so v is zero and such an entry is always invalid
  function automatic logic [63:0] read_entry(input logic [PADDR_W-1:0] addr);
    logic [63:0] data;
    if (entries.exists(addr)) begin
      data = entries[addr];
    end else begin
      data = 64'({addr, 8'h00});
    end
    return data;
  endfunction

  // one generator step per request, the top bits give the wait in cycles
  function automatic logic [1:0] draw_delay();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[17:16];
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      busy_q  <= 1'b0;
      delay_q <= '0;
    end else if (ack_q) begin
      // the ack is held until the master lets go of the request
      if (!mem_req_i) begin
        ack_q <= 1'b0;
      end
    end else if (busy_q) begin
      if (delay_q == 2'd0) begin
        ack_q   <= 1'b1;
        rdata_q <= read_entry(mem_addr_i);
        busy_q  <= 1'b0;
      end else begin
        delay_q <= delay_q - 2'd1;
      end
    end else if (mem_req_i) begin
      busy_q  <= 1'b1;
      delay_q <= draw_delay();
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;

endmodule

// ==== dv/tb_ptw.sv ====
/*
 * Testbench for the Sv39 page table walker
 * Builds page tables in the memory model, plays the TLB side of the walk
 * handshake, predicts every response from the Sv39 rules and checks the
 * responses and both handshakes with concurrent assertions
 */

`timescale 1ns/1ps

module tb_ptw;

  import ptw_pkg::*;

  localparam int unsigned PADDR_W        = 56;
  localparam int unsigned MAX_WALKS      = 40;
  localparam int unsigned TIMEOUT_CYCLES = MAX_WALKS * 4 * 12;
  localparam int unsigned RANDOM_WALKS   = 20;

  // the root table holds one slot per directed case and points to the lower tables
  localparam ppn_t ROOT_PPN = 44'h100;
  localparam ppn_t T3A_PPN  = 44'h200;
  localparam ppn_t T3B_PPN  = 44'h201;
  localparam ppn_t T2A_PPN  = 44'h300;

  // control bytes are d a g u x w r v from the top bit down
  localparam pte_ctrl_t CTRL_PTR        = 8'h01;
  localparam pte_ctrl_t CTRL_LEAF       = 8'hCF;
  localparam pte_ctrl_t CTRL_NO_ACCESS  = 8'h8F;
  localparam pte_ctrl_t CTRL_WRITE_ONLY = 8'h45;
  localparam pte_ctrl_t CTRL_INVALID    = 8'hCE;

  logic               clk_i;
  logic               rst_n_i;
  logic               walk_req_i;
  ptw_req_t           walk_data_i;
  logic               walk_ack_o;
  ptw_resp_t          walk_resp_o;
  logic               mem_req_o;
  logic [PADDR_W-1:0] mem_addr_o;
  logic               mem_ack_i;
  logic [63:0]        mem_rdata_i;

  ptw_resp_t   expected_resp = '0;
  logic        walk_started  = 1'b0;
  logic        ack_prev_q    = 1'b0;
  int unsigned cyc_cnt       = 0;
  int unsigned err_cnt       = 0;
  int unsigned walk_cnt      = 0;
  int unsigned resp_cnt      = 0;
  int unsigned rng_q         = 92;

  ptw_top #(
    .PADDR_W (PADDR_W)
  ) ptw_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .walk_req_i  (walk_req_i),
    .walk_data_i (walk_data_i),
    .walk_ack_o  (walk_ack_o),
    .walk_resp_o (walk_resp_o),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  tb_pt_mem #(
    .PADDR_W (PADDR_W)
  ) tb_pt_mem_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_req_i   (mem_req_o),
    .mem_addr_i  (mem_addr_o),
    .mem_ack_o   (mem_ack_i),
    .mem_rdata_o (mem_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // the run is bounded even if a handshake never completes
  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: walks still running after %0d cycles", TIMEOUT_CYCLES);
      $display("walks %0d, responses %0d, errors %0d", walk_cnt, resp_cnt, err_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  // each rising edge of the walk ack counts as one response from the DUT
  always @(posedge clk_i) begin
    ack_prev_q <= walk_ack_o;
    if (rst_n_i && walk_ack_o && !ack_prev_q) begin
      resp_cnt <= resp_cnt + 1;
    end
  end

  function automatic int unsigned next_random();
    rng_q = rng_q * 32'd1103515245 + 32'd12345;
    return rng_q >> 16;
  endfunction

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("ERROR: %s", msg);
  endtask

  function automatic pte_t make_pte(input ppn_t ppn, input pte_ctrl_t ctrl);
    pte_t pte;
    pte      = '0;
    pte.ppn  = ppn;
    pte.ctrl = ctrl;
    return pte;
  endfunction

  // an entry sits at the table page plus eight bytes per index
  task automatic place_pte(input ppn_t table_ppn, input logic [8:0] idx,
                           input ppn_t ppn, input pte_ctrl_t ctrl);
    tb_pt_mem_i.write_entry({table_ppn, idx, 3'b000}, make_pte(ppn, ctrl));
  endtask

  // walks the stored tables by the Sv39 rules and stops at a leaf or a fault
  function automatic ptw_resp_t predict_walk(input ptw_req_t req);
    ptw_resp_t  resp;
    pte_t       pte;
    ppn_t       base;
    pte_level_e lvl_name;
    logic [8:0] idx;
    logic       leaf;
    logic       fault;
    logic       stop;
    int         lvl;
    resp = '0;
    base = req.root;
    stop = 1'b0;
    for (lvl = 0; lvl < 3; lvl++) begin
      if (!stop) begin
        case (lvl)
          0: begin
            idx      = req.vpn.vp2;
            lvl_name = L3;
          end
          1: begin
            idx      = req.vpn.vp1;
            lvl_name = L2;
          end
          default: begin
            idx      = req.vpn.vp0;
            lvl_name = L1;
          end
        endcase
        pte   = pte_t'(tb_pt_mem_i.read_entry({base, idx, 3'b000}));
        leaf  = pte.ctrl.r | pte.ctrl.x;
        fault = !pte.ctrl.v || (pte.ctrl.w && !pte.ctrl.r);
        if (!fault && leaf) begin
          // superpages need their low ppn slices clear
          fault = !pte.ctrl.a ||
                  ((lvl == 0) && ({pte.ppn.p1, pte.ppn.p0} != '0)) ||
                  ((lvl == 1) && (pte.ppn.p0 != '0));
        end
        if (!fault && !leaf && (lvl == 2)) begin
          fault = 1'b1;
        end
        if (fault || leaf) begin
          resp.ppn   = pte.ppn;
          resp.level = lvl_name;
          resp.ctrl  = pte.ctrl;
          resp.exc   = fault ? PageFault : NoException;
          stop       = 1'b1;
        end else begin
          base = pte.ppn;
        end
      end
    end
    return resp;
  endfunction

  // the TLB holds each request for 0 to 3 extra cycles once it is acknowledged
  task automatic run_walk(input logic [8:0] vp2, input logic [8:0] vp1,
                          input logic [8:0] vp0);
    ptw_req_t    req;
    int unsigned hold;
    req.vpn.vp2   = vp2;
    req.vpn.vp1   = vp1;
    req.vpn.vp0   = vp0;
    req.root      = ROOT_PPN;
    expected_resp = predict_walk(req);
    hold          = next_random() % 4;
    @(posedge clk_i);
    walk_req_i   <= 1'b1;
    walk_data_i  <= req;
    walk_started <= 1'b1;
    walk_cnt++;
    do @(negedge clk_i); while (!walk_ack_o);
    repeat (hold) @(posedge clk_i);
    @(posedge clk_i);
    walk_req_i <= 1'b0;
    do @(negedge clk_i); while (walk_ack_o);
  endtask

  a_resp_match : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(walk_ack_o) |-> (walk_resp_o == expected_resp))
    else begin
      err_cnt++;
      $display("** Error: walk_resp_o = %h, expected %h", walk_resp_o, expected_resp);
    end

  // covers the reset cycles and the idle time before the first walk
  a_quiet_start : assert property (@(posedge clk_i)
    ((cyc_cnt != 0) && !walk_started) |-> (!walk_ack_o && !mem_req_o))
    else note_failure("walk_ack_o or mem_req_o active before the first walk");

  a_ack_needs_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(walk_ack_o) |-> walk_req_i)
    else note_failure("walk ack rose without a request");

  a_ack_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (walk_ack_o && walk_req_i) |=> walk_ack_o)
    else note_failure("walk ack dropped while the request was still high");

  a_ack_drop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(walk_ack_o) |-> !walk_req_i)
    else note_failure("walk ack fell before the request was dropped");

  a_resp_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    walk_ack_o |=> (!walk_ack_o || $stable(walk_resp_o)))
    else note_failure("walk response changed while acknowledged");

  a_mem_ack_needs_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_ack_i) |-> mem_req_o)
    else note_failure("memory ack rose without a request");

  a_mem_req_drop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(mem_req_o) |-> mem_ack_i)
    else note_failure("memory request dropped before the ack");

  a_mem_ack_drop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(mem_ack_i) |-> !mem_req_o)
    else note_failure("memory ack fell while the request was high");

  a_mem_req_rise : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_req_o) |-> !mem_ack_i)
    else note_failure("memory request rose before the last ack fell");

  initial begin
    rst_n_i     = 1'b0;
    walk_req_i  = 1'b0;
    walk_data_i = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(negedge clk_i);

    place_pte(ROOT_PPN, 9'd1, T3A_PPN, CTRL_PTR);
    place_pte(ROOT_PPN, 9'd2, ppn_t'({26'h3, 9'h0, 9'h0}), CTRL_LEAF);
    place_pte(ROOT_PPN, 9'd3, T3B_PPN, CTRL_PTR);
    place_pte(ROOT_PPN, 9'd4, ppn_t'({26'h6, 9'h1, 9'h0}), CTRL_LEAF);
    place_pte(ROOT_PPN, 9'd5, ppn_t'({26'h7, 9'h0, 9'h3}), CTRL_LEAF);
    place_pte(ROOT_PPN, 9'd6, ppn_t'(44'h0), CTRL_INVALID);
    place_pte(T3A_PPN, 9'd5, T2A_PPN, CTRL_PTR);
    place_pte(T3B_PPN, 9'd4, ppn_t'({26'h5, 9'h11, 9'h0}), CTRL_LEAF);
    place_pte(T3B_PPN, 9'd6, ppn_t'({26'h5, 9'h12, 9'h2}), CTRL_LEAF);
    place_pte(T3B_PPN, 9'd8, ppn_t'(44'h0), CTRL_INVALID);
    place_pte(T3B_PPN, 9'd9, ppn_t'({26'h8, 9'h0, 9'h0}), CTRL_WRITE_ONLY);
    place_pte(T2A_PPN, 9'd7, ppn_t'({26'h12, 9'h34, 9'h56}), CTRL_LEAF);
    place_pte(T2A_PPN, 9'd8, ppn_t'({26'h13, 9'h1, 9'h2}), CTRL_NO_ACCESS);
    place_pte(T2A_PPN, 9'd9, ppn_t'(44'h400), CTRL_PTR);

    // a few idle cycles show the outputs stay quiet after reset
    repeat (5) @(negedge clk_i);

    // 4 KiB leaf after three levels
    run_walk(9'd1, 9'd5, 9'd7);
    // aligned gibi-page and mebi-page
    run_walk(9'd2, 9'd0, 9'd0);
    run_walk(9'd3, 9'd4, 9'd0);
    // misaligned superpages
    run_walk(9'd4, 9'd0, 9'd0);
    run_walk(9'd5, 9'd0, 9'd0);
    run_walk(9'd3, 9'd6, 9'd0);
    // invalid at L3, an unwritten slot, invalid at L2, write without read
    run_walk(9'd6, 9'd0, 9'd0);
    run_walk(9'd7, 9'd0, 9'd0);
    run_walk(9'd3, 9'd8, 9'd0);
    run_walk(9'd3, 9'd9, 9'd0);
    // access bit clear and a pointer at the last level
    run_walk(9'd1, 9'd5, 9'd8);
    run_walk(9'd1, 9'd5, 9'd9);

    // random indices over the same tables mostly end in short faulting walks
    repeat (RANDOM_WALKS) begin
      run_walk(9'(next_random() % 8), 9'(next_random() % 10), 9'(next_random() % 10));
    end

    repeat (2) @(negedge clk_i);
    if (resp_cnt != walk_cnt) begin
      note_failure("the number of walk responses differs from the number of walks");
    end
    $display("walks %0d, responses %0d, errors %0d", walk_cnt, resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hw/ptw_pkg.sv
hw/pte_checker.sv
hw/ptw_mem_port.sv
hw/ptw_ctrl.sv
hw/ptw_top.sv
dv/tb_pt_mem.sv
dv/tb_ptw.sv

// ==== Makefile ====
# Verilator simulation of the Sv39 page table walker

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_ptw
	@out=$$(./obj_dir/Vtb_ptw); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
